//--- Bender.yml
package:
  name: dbg_comm

sources:
  - files:
      - design/dbg_comm_pkg.sv
      - design/dbg_comm_to_wb.sv
      - design/wb_bank_decode.sv
      - design/wb_ram_bank.sv
      - design/wb_rdata_merge.sv
      - design/dbg_comm_top.sv
  - target: test
    files:
      - dv/dbg_comm_tb.sv

//--- design/dbg_comm_pkg.sv
// Shared definitions for the debug bridge and its memory subsystem.
// Holds the command and ack byte codes, the bank geometry, the FSM state
// codes and the bus data word type. Other files refer to these by scoped name.

`default_nettype none

package dbg_comm_pkg;

	// --------------------------------------------------
	// command and response codes
	// --------------------------------------------------
	localparam logic [7:0] CMD_NOP       = 8'h00;
	localparam logic [7:0] CMD_STATUS    = 8'h01;
	localparam logic [7:0] CMD_WRITE     = 8'h02;
	localparam logic [7:0] CMD_READ      = 8'h03;

	localparam logic [7:0] ACK_FLAG      = 8'h80;
	localparam logic [7:0] ACK_WRITE_END = 8'hC2;

	// --------------------------------------------------
	// bus and memory geometry
	// --------------------------------------------------
	localparam int ADR_BYTES    = 4;
	// log2 of bytes per bus word
	localparam int DAT_SIZE     = 2;
	localparam int NUM_BANKS    = 4;
	localparam int BANK_WORDS   = 64;
	// byte address bit where the bank index starts
	localparam int BANK_SEL_LSB = 8;
	localparam int BANK_IDX_W   = $clog2(NUM_BANKS);
	localparam int BANK_ADR_W   = $clog2(BANK_WORDS);

	// status byte before the bridge adds endian in bit 7
	localparam logic [7:0] STATUS_BASE = {2'b00, 2'(DAT_SIZE), 4'(ADR_BYTES)};

	// bridge FSM states
	localparam logic [2:0] ST_IDLE      = 3'd0;
	localparam logic [2:0] ST_ACK       = 3'd1;
	localparam logic [2:0] ST_STATUS    = 3'd2;
	localparam logic [2:0] ST_ADR       = 3'd3;
	localparam logic [2:0] ST_SIZE      = 3'd4;
	localparam logic [2:0] ST_WRITE     = 3'd5;
	localparam logic [2:0] ST_WRITE_END = 3'd6;
	localparam logic [2:0] ST_READ      = 3'd7;

	// one bus word seen whole or as byte lanes
	typedef union packed {
		logic [(8 << DAT_SIZE)-1:0]         word;
		logic [(1 << DAT_SIZE)-1:0][7:0]    lane;
	} wb_word_u;

endpackage

`default_nettype wire

//--- design/dbg_comm_to_wb.sv
// Debug bridge core. Parses the host byte stream (nop, status, write, read),
// answers each command and turns writes and reads into bus word accesses.
// The endian input picks the address byte order and the byte lane mapping.

`timescale 1ns/1ps
`default_nettype none

module dbg_comm_to_wb (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       endian_i,

	input  wire  [7:0]                rx_data_i,
	input  wire                       rx_valid_i,
	output logic                      rx_ready_o,
	output logic [7:0]                tx_data_o,
	output logic                      tx_valid_o,
	input  wire                       tx_ready_i,

	output logic [29:0]               wb_adr_o,
	output dbg_comm_pkg::wb_word_u    wb_dat_o,
	input  wire  dbg_comm_pkg::wb_word_u wb_dat_i,
	output logic [3:0]                wb_sel_o,
	output logic                      wb_we_o,
	output logic                      wb_stb_o,
	input  wire                       wb_ack_i
);

	logic [2:0]              state_q, state_n;
	logic [7:0]              cmd_q, cmd_n;
	logic [1:0]              cnt_q, cnt_n;
	logic [31:0]             adr_q, adr_n;
	logic [7:0]              size_q, size_n;
	logic                    done_q, done_n;
	logic                    rd_ok_q, rd_ok_n;
	dbg_comm_pkg::wb_word_u  rd_word_q, rd_word_n;

	logic                    rx_ready_n;
	logic [7:0]              tx_data_n;
	logic                    tx_valid_n;
	logic [29:0]             wb_adr_n;
	dbg_comm_pkg::wb_word_u  wb_dat_n;
	logic [3:0]              wb_sel_n;
	logic                    wb_we_n;
	logic                    wb_stb_n;

	logic                    rx_take;
	logic                    tx_take;
	logic                    tx_free;
	logic [1:0]              lane;

	assign rx_take = rx_valid_i && rx_ready_o;
	assign tx_take = tx_valid_o && tx_ready_i;
	// room for one more tx byte this cycle
	assign tx_free = !tx_valid_o || tx_ready_i;
	// big endian mirrors the lane order
	assign lane    = adr_q[1:0] ^ {2{endian_i}};

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_n    = state_q;
		cmd_n      = cmd_q;
		cnt_n      = cnt_q;
		adr_n      = adr_q;
		size_n     = size_q;
		done_n     = done_q;
		rd_ok_n    = rd_ok_q;
		rd_word_n  = rd_word_q;
		tx_data_n  = tx_data_o;
		tx_valid_n = tx_valid_o && !tx_ready_i;
		wb_adr_n   = wb_adr_o;
		wb_dat_n   = wb_dat_o;
		wb_sel_n   = wb_sel_o;
		wb_we_n    = wb_we_o;
		wb_stb_n   = wb_stb_o;

		case (state_q)
		dbg_comm_pkg::ST_IDLE: begin
			if (rx_take) begin
				cmd_n      = rx_data_i;
				tx_data_n  = rx_data_i | dbg_comm_pkg::ACK_FLAG;
				tx_valid_n = 1'b1;
				state_n    = dbg_comm_pkg::ST_ACK;
			end
		end
		dbg_comm_pkg::ST_ACK: begin
			cnt_n = 2'd0;
			if (tx_take) begin
				case (cmd_q)
				dbg_comm_pkg::CMD_STATUS: begin
					tx_data_n  = dbg_comm_pkg::STATUS_BASE | {endian_i, 7'b0};
					tx_valid_n = 1'b1;
					state_n    = dbg_comm_pkg::ST_STATUS;
				end
				dbg_comm_pkg::CMD_WRITE,
				dbg_comm_pkg::CMD_READ:  state_n = dbg_comm_pkg::ST_ADR;
				default:                 state_n = dbg_comm_pkg::ST_IDLE;
				endcase
			end
		end
		dbg_comm_pkg::ST_STATUS,
		dbg_comm_pkg::ST_WRITE_END: begin
			if (tx_take)
				state_n = dbg_comm_pkg::ST_IDLE;
		end
		dbg_comm_pkg::ST_ADR: begin
			if (rx_take) begin
				adr_n[(cnt_q ^ {2{endian_i}})*8 +: 8] = rx_data_i;
				cnt_n = cnt_q + 2'd1;
				if (cnt_q == 2'(dbg_comm_pkg::ADR_BYTES - 1))
					state_n = dbg_comm_pkg::ST_SIZE;
			end
		end
		dbg_comm_pkg::ST_SIZE: begin
			if (rx_take) begin
				size_n  = rx_data_i;
				done_n  = 1'b0;
				rd_ok_n = 1'b0;
				if (cmd_q == dbg_comm_pkg::CMD_WRITE) begin
					wb_sel_n = 4'b0000;
					state_n  = dbg_comm_pkg::ST_WRITE;
				end else begin
					state_n  = dbg_comm_pkg::ST_READ;
				end
			end
		end
		dbg_comm_pkg::ST_WRITE: begin
			if (wb_stb_o) begin
				if (wb_ack_i) begin
					wb_stb_n = 1'b0;
					wb_sel_n = 4'b0000;
					if (done_q) begin
						tx_data_n  = dbg_comm_pkg::ACK_WRITE_END;
						tx_valid_n = 1'b1;
						state_n    = dbg_comm_pkg::ST_WRITE_END;
					end
				end
			end else if (rx_take) begin
				wb_dat_n.lane[lane] = rx_data_i;
				wb_sel_n[lane]      = 1'b1;
				adr_n               = adr_q + 32'd1;
				size_n              = size_q - 8'd1;
				// flush at the top lane of a word or on the last byte
				if (adr_q[1:0] == 2'b11 || size_q == 8'd0) begin
					wb_adr_n = adr_q[31:2];
					wb_we_n  = 1'b1;
					wb_stb_n = 1'b1;
				end
				if (size_q == 8'd0)
					done_n = 1'b1;
			end
		end
		dbg_comm_pkg::ST_READ: begin
			if (done_q) begin
				if (tx_take)
					state_n = dbg_comm_pkg::ST_IDLE;
			end else begin
				if (wb_stb_o) begin
					if (wb_ack_i) begin
						wb_stb_n  = 1'b0;
						rd_word_n = wb_dat_i;
						rd_ok_n   = 1'b1;
					end
				end else if (!rd_ok_q && tx_free) begin
					// fetch the word holding the current byte
					wb_adr_n = adr_q[31:2];
					wb_we_n  = 1'b0;
					wb_sel_n = 4'b1111;
					wb_stb_n = 1'b1;
				end
				if (rd_ok_q && tx_free) begin
					tx_data_n  = rd_word_q.lane[lane];
					tx_valid_n = 1'b1;
					adr_n      = adr_q + 32'd1;
					size_n     = size_q - 8'd1;
					if (adr_q[1:0] == 2'b11)
						rd_ok_n = 1'b0;
					if (size_q == 8'd0)
						done_n = 1'b1;
				end
			end
		end
		default: state_n = dbg_comm_pkg::ST_IDLE;
		endcase

		// rx open in the byte taking states but shut while a write word is out
		rx_ready_n = (state_n == dbg_comm_pkg::ST_IDLE) ||
			(state_n == dbg_comm_pkg::ST_ADR) ||
			(state_n == dbg_comm_pkg::ST_SIZE) ||
			(state_n == dbg_comm_pkg::ST_WRITE && !wb_stb_n && !done_n);
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q    <= dbg_comm_pkg::ST_IDLE;
			done_q     <= 1'b0;
			rd_ok_q    <= 1'b0;
			rx_ready_o <= 1'b0;
			tx_valid_o <= 1'b0;
			wb_stb_o   <= 1'b0;
		end else begin
			state_q    <= state_n;
			done_q     <= done_n;
			rd_ok_q    <= rd_ok_n;
			rx_ready_o <= rx_ready_n;
			tx_valid_o <= tx_valid_n;
			wb_stb_o   <= wb_stb_n;
		end
	end

	always_ff @(posedge clk) begin
		cmd_q     <= cmd_n;
		cnt_q     <= cnt_n;
		adr_q     <= adr_n;
		size_q    <= size_n;
		rd_word_q <= rd_word_n;
		tx_data_o <= tx_data_n;
		wb_adr_o  <= wb_adr_n;
		wb_dat_o  <= wb_dat_n;
		wb_sel_o  <= wb_sel_n;
		wb_we_o   <= wb_we_n;
	end

	// bus request held steady until the slave answers
	assert property (@(posedge clk) disable iff (reset)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o) &&
			$stable(wb_sel_o) && $stable(wb_we_o))
		else $error("bus request changed before ack");

	// a stalled tx byte must not change
	assert property (@(posedge clk) disable iff (reset)
		tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
		else $error("tx byte changed while stalled");

endmodule

`default_nettype wire

//--- design/dbg_comm_top.sv
// Top level of the debug bridge. Byte stream in and out, endian select,
// and behind the bridge a decoder, the RAM banks and the read merge.

`timescale 1ns/1ps
`default_nettype none

module dbg_comm_top (
	input  wire         clk,
	input  wire         reset,
	input  wire         endian_i,
	input  wire  [7:0]  rx_data_i,
	input  wire         rx_valid_i,
	output logic        rx_ready_o,
	output logic [7:0]  tx_data_o,
	output logic        tx_valid_o,
	input  wire         tx_ready_i
);

	logic [29:0]                                        wb_adr;
	dbg_comm_pkg::wb_word_u                             wb_dat_w;
	dbg_comm_pkg::wb_word_u                             wb_dat_r;
	logic [3:0]                                         wb_sel;
	logic                                               wb_we;
	logic                                               wb_stb;
	logic                                               wb_ack;

	logic [dbg_comm_pkg::NUM_BANKS-1:0]                 bank_stb;
	logic [dbg_comm_pkg::NUM_BANKS-1:0]                 bank_ack;
	dbg_comm_pkg::wb_word_u [dbg_comm_pkg::NUM_BANKS-1:0] bank_dat;
	logic                                               oor_ack;

	dbg_comm_to_wb u_bridge (
		.clk        (clk),
		.reset      (reset),
		.endian_i   (endian_i),
		.rx_data_i  (rx_data_i),
		.rx_valid_i (rx_valid_i),
		.rx_ready_o (rx_ready_o),
		.tx_data_o  (tx_data_o),
		.tx_valid_o (tx_valid_o),
		.tx_ready_i (tx_ready_i),
		.wb_adr_o   (wb_adr),
		.wb_dat_o   (wb_dat_w),
		.wb_dat_i   (wb_dat_r),
		.wb_sel_o   (wb_sel),
		.wb_we_o    (wb_we),
		.wb_stb_o   (wb_stb),
		.wb_ack_i   (wb_ack)
	);

	wb_bank_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.adr_i      (wb_adr),
		.stb_i      (wb_stb),
		.bank_stb_o (bank_stb),
		.oor_ack_o  (oor_ack)
	);

	// banks share address, data and selects and differ only in the strobe
	for (genvar i = 0; i < dbg_comm_pkg::NUM_BANKS; i++) begin : g_bank
		wb_ram_bank u_bank (
			.clk   (clk),
			.reset (reset),
			.stb_i (bank_stb[i]),
			.we_i  (wb_we),
			.adr_i (wb_adr[dbg_comm_pkg::BANK_ADR_W-1:0]),
			.sel_i (wb_sel),
			.dat_i (wb_dat_w),
			.dat_o (bank_dat[i]),
			.ack_o (bank_ack[i])
		);
	end

	wb_rdata_merge u_merge (
		.bank_ack_i (bank_ack),
		.bank_dat_i (bank_dat),
		.oor_ack_i  (oor_ack),
		.ack_o      (wb_ack),
		.dat_o      (wb_dat_r)
	);

endmodule

`default_nettype wire

//--- design/wb_bank_decode.sv
// Bus address decoder for the RAM banks.
// Raises the strobe of the addressed bank; an address above the banks is
// answered here with a one-cycle ack so the bridge never waits forever.

`timescale 1ns/1ps
`default_nettype none

module wb_bank_decode (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [29:0]                         adr_i,
	input  wire                                 stb_i,
	output logic [dbg_comm_pkg::NUM_BANKS-1:0]  bank_stb_o,
	output logic                                oor_ack_o
);

	logic [dbg_comm_pkg::BANK_IDX_W-1:0] idx;
	logic                                oor;

	// bank index sits right above the word index
	assign idx = adr_i[dbg_comm_pkg::BANK_ADR_W +: dbg_comm_pkg::BANK_IDX_W];
	assign oor = |adr_i[29:dbg_comm_pkg::BANK_ADR_W + dbg_comm_pkg::BANK_IDX_W];

	always_comb begin
		bank_stb_o = '0;
		if (stb_i && !oor)
			bank_stb_o[idx] = 1'b1;
	end

	// held strobe gets one ack only
	always_ff @(posedge clk) begin
		if (reset) begin
			oor_ack_o <= 1'b0;
		end else begin
			oor_ack_o <= stb_i && oor && !oor_ack_o;
		end
	end

	// at most one bank strobe, and none while the decoder itself acks
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({bank_stb_o, oor_ack_o}))
		else $error("bank strobe together with another strobe or the decoder ack");

endmodule

`default_nettype wire

//--- design/wb_ram_bank.sv
// One RAM bank on the bus. Word addressed, byte-masked writes,
// read data and ack registered one cycle after the strobe.
// Instantiated once per bank by the top level.

`timescale 1ns/1ps
`default_nettype none

module wb_ram_bank (
	input  wire                                   clk,
	input  wire                                   reset,
	input  wire                                   stb_i,
	input  wire                                   we_i,
	input  wire  [dbg_comm_pkg::BANK_ADR_W-1:0]   adr_i,
	input  wire  [3:0]                            sel_i,
	input  wire  dbg_comm_pkg::wb_word_u          dat_i,
	output dbg_comm_pkg::wb_word_u                dat_o,
	output logic                                  ack_o
);

	dbg_comm_pkg::wb_word_u mem [dbg_comm_pkg::BANK_WORDS];
	logic                   access;

	// master still holds stb in the cycle after an ack
	assign access = stb_i && !ack_o;

	always_ff @(posedge clk) begin
		if (access) begin
			if (we_i) begin
				for (int k = 0; k < 4; k++) begin
					if (sel_i[k])
						mem[adr_i].lane[k] <= dat_i.lane[k];
				end
			end
			dat_o <= mem[adr_i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

endmodule

`default_nettype wire

//--- design/wb_rdata_merge.sv
// Bus response merge. ORs the bank acks with the decoder ack and
// passes the read data of the bank that answers; decoder acks read zero.

`timescale 1ns/1ps
`default_nettype none

module wb_rdata_merge (
	input  wire  [dbg_comm_pkg::NUM_BANKS-1:0]                        bank_ack_i,
	input  wire  dbg_comm_pkg::wb_word_u [dbg_comm_pkg::NUM_BANKS-1:0] bank_dat_i,
	input  wire                                                       oor_ack_i,
	output logic                                                      ack_o,
	output dbg_comm_pkg::wb_word_u                                    dat_o
);

	always_comb begin
		ack_o      = oor_ack_i || (|bank_ack_i);
		dat_o.word = '0;
		for (int i = 0; i < dbg_comm_pkg::NUM_BANKS; i++) begin
			if (bank_ack_i[i])
				dat_o = bank_dat_i[i];
		end
	end

	// decoder and banks never answer together
	always_comb begin
		assert final ($onehot0({bank_ack_i, oor_ack_i}))
			else $error("more than one ack source active");
	end

endmodule

`default_nettype wire

//--- dv/dbg_comm_cases.txt
# name endian ncmd cmd_bytes... nexp expected_bytes...
# counts are decimal, endian and bytes are hex; memory persists between cases
nop_le 0 1 00 1 80
nop_be 1 1 00 1 80
status_le 0 1 01 2 81 24
status_be 1 1 01 2 81 A4
unknown_44 0 1 44 1 C4
unknown_7f 1 1 7F 1 FF
# aligned word in both byte orders
write_le_w0 0 10 02 00 00 00 00 03 11 22 33 44 2 82 C2
read_le_w0 0 6 03 00 00 00 00 03 5 83 11 22 33 44
read_be_w0 1 6 03 00 00 00 00 03 5 83 44 33 22 11
write_be_w4 1 10 02 00 00 00 10 03 A1 B2 C3 D4 2 82 C2
read_be_w4 1 6 03 00 00 00 10 03 5 83 A1 B2 C3 D4
read_le_w4 0 6 03 10 00 00 00 03 5 83 D4 C3 B2 A1
# unaligned write between known bytes
fill_40 0 18 02 40 00 00 00 0B 30 31 32 33 34 35 36 37 38 39 3A 3B 2 82 C2
write_43 0 12 02 43 00 00 00 05 E0 E1 E2 E3 E4 E5 2 82 C2
read_40 0 6 03 40 00 00 00 0B 13 83 30 31 32 E0 E1 E2 E3 E4 E5 39 3A 3B
# across bank boundaries
write_fe 0 10 02 FE 00 00 00 03 5A 5B 5C 5D 2 82 C2
read_fe 0 6 03 FE 00 00 00 03 5 83 5A 5B 5C 5D
write_1fe_be 1 10 02 00 00 01 FE 03 66 77 88 99 2 82 C2
read_1fe_be 1 6 03 00 00 01 FE 03 5 83 66 77 88 99
# above the last bank
write_oor 0 10 02 00 10 00 00 03 DE AD BE EF 2 82 C2
read_oor 0 6 03 00 10 00 00 03 5 83 00 00 00 00
read_oor_be 1 6 03 80 00 00 00 01 3 83 00 00
read_w0_again 0 6 03 00 00 00 00 03 5 83 11 22 33 44
nop_end 0 1 00 1 80

//--- dv/dbg_comm_tb.sv
// File-driven testbench for the debug bridge top level.
// Reads command streams and expected responses from dv/dbg_comm_cases.txt,
// sends them with random gaps on rx and checks the answers under random tx stalls.

`timescale 1ns/1ps
`default_nettype none

module dbg_comm_tb;

	localparam int SEED      = 45409;
	localparam int RESET_CYC = 16;
	// watchdog budget per byte in the case file
	localparam int BYTE_CYC  = 40;
	localparam int BYTE_WAIT = 200;
	localparam int DRAIN_CYC = 24;

	logic       clk;
	logic       reset;
	logic       endian;
	logic [7:0] rx_data;
	logic       rx_valid;
	logic       rx_ready;
	logic [7:0] tx_data;
	logic       tx_valid;
	logic       tx_ready;

	// cases as loaded from the file with all bytes kept flat behind offsets
	logic [8*32-1:0] case_name[$];
	logic            case_endian[$];
	int              cmd_ofs[$];
	int              cmd_len[$];
	int              exp_ofs[$];
	int              exp_len[$];
	logic [7:0]      cmd_bytes[$];
	logic [7:0]      exp_bytes[$];

	integer          seed;
	int              total_bytes;
	bit              loaded;
	int              checks;
	int              errors;
	int              case_errors;
	int              failed_cases;
	logic [8*32-1:0] cur_name;

	dbg_comm_top UUT (
		.clk        (clk),
		.reset      (reset),
		.endian_i   (endian),
		.rx_data_i  (rx_data),
		.rx_valid_i (rx_valid),
		.rx_ready_o (rx_ready),
		.tx_data_o  (tx_data),
		.tx_valid_o (tx_valid),
		.tx_ready_i (tx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// case file
	// --------------------------------------------------
	task automatic load_cases(output bit ok);
		int               fd;
		int               rc;
		int               n;
		logic [8*32-1:0]  tok;
		logic [8*128-1:0] rest;
		logic [7:0]       e;
		logic [7:0]       b;
		ok = 1'b0;
		total_bytes = 0;
		fd = $fopen("dv/dbg_comm_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file dv/dbg_comm_cases.txt");
			return;
		end
		while (!$feof(fd)) begin
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1)
				break;
			// drop the rest of a comment line
			if (tok == "#") begin
				rc = $fgets(rest, fd);
				continue;
			end
			rc = $fscanf(fd, "%h %d", e, n);
			case_name.push_back(tok);
			case_endian.push_back(e[0]);
			cmd_ofs.push_back(cmd_bytes.size());
			cmd_len.push_back(n);
			total_bytes += n;
			for (int i = 0; i < n; i++) begin
				rc = $fscanf(fd, "%h", b);
				cmd_bytes.push_back(b);
			end
			rc = $fscanf(fd, "%d", n);
			exp_ofs.push_back(exp_bytes.size());
			exp_len.push_back(n);
			total_bytes += n;
			for (int i = 0; i < n; i++) begin
				rc = $fscanf(fd, "%h", b);
				exp_bytes.push_back(b);
			end
		end
		$fclose(fd);
		ok = (case_name.size() > 0);
		if (!ok)
			$display("the case file holds no cases");
	endtask

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0s tx_data_o byte %0d: got %02h expected %02h",
				cur_name, idx, got, exp);
			errors++;
			case_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string sig);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] reset %0s: got %0h expected %0h", sig, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp);
		checks++;
		if (got < exp) begin
			$display("%0s timed out waiting for response byte %0d of %0d",
				cur_name, got + 1, exp);
			errors++;
			case_errors++;
		end else if (got != exp) begin
			$display("[FAIL] %0s tx_valid_o byte count: got %02h expected %02h",
				cur_name, got, exp);
			errors++;
			case_errors++;
		end
	endtask

	// --------------------------------------------------
	// stream drivers
	// --------------------------------------------------
	task automatic send_bytes(input int c);
		int gap;
		for (int i = 0; i < cmd_len[c]; i++) begin
			gap = $random(seed) & 3;
			if (gap != 0) begin
				rx_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			rx_data  <= cmd_bytes[cmd_ofs[c] + i];
			rx_valid <= 1'b1;
			@(posedge clk);
			while (!rx_ready)
				@(posedge clk);
		end
		rx_valid <= 1'b0;
	endtask

	task automatic collect_bytes(input int c, output int got);
		int idle;
		got  = 0;
		idle = 0;
		while (got < exp_len[c] && idle < BYTE_WAIT) begin
			tx_ready <= (($random(seed) & 3) != 0);
			@(posedge clk);
			if (tx_valid && tx_ready) begin
				check_byte(tx_data, exp_bytes[exp_ofs[c] + got], got);
				got++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		// anything after the last expected byte is extra
		tx_ready <= 1'b1;
		repeat (DRAIN_CYC) begin
			@(posedge clk);
			if (tx_valid && tx_ready)
				got++;
		end
		tx_ready <= 1'b0;
	endtask

	task automatic run_case(input int c);
		int got;
		cur_name    = case_name[c];
		case_errors = 0;
		endian <= case_endian[c];
		@(posedge clk);
		fork
			send_bytes(c);
			collect_bytes(c, got);
		join
		check_count(got, exp_len[c]);
		if (case_errors == 0) begin
			$display("[ OK ] %0s", cur_name);
		end else begin
			$display("[ERR ] %0s with %0d errors", cur_name, case_errors);
			failed_cases++;
		end
	endtask

	initial begin : main_seq
		bit ok;
		seed         = SEED;
		reset        = 1'b1;
		endian       = 1'b0;
		rx_data      = 8'h00;
		rx_valid     = 1'b0;
		tx_ready     = 1'b0;
		checks       = 0;
		errors       = 0;
		failed_cases = 0;
		loaded       = 1'b0;
		load_cases(ok);
		if (!ok) begin
			$display("Simulation failed");
		end else begin
			loaded = 1'b1;
			repeat (RESET_CYC) @(posedge clk);
			// both stream outputs stay quiet through reset
			check_flag(rx_ready, 1'b0, "rx_ready_o");
			check_flag(tx_valid, 1'b0, "tx_valid_o");
			reset <= 1'b0;
			@(posedge clk);
			for (int c = 0; c < case_name.size(); c++)
				run_case(c);
			$display("cases %0d, failed cases %0d, checks %0d, errors %0d",
				case_name.size(), failed_cases, checks, errors);
			if (errors == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (loaded);
		repeat (RESET_CYC + BYTE_CYC * total_bytes) @(posedge clk);
		$display("watchdog expired after %0d cycles, a case never finished",
			RESET_CYC + BYTE_CYC * total_bytes);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
design/dbg_comm_pkg.sv
design/dbg_comm_to_wb.sv
design/wb_bank_decode.sv
design/wb_ram_bank.sv
design/wb_rdata_merge.sv
design/dbg_comm_top.sv
dv/dbg_comm_tb.sv
